/* Makefile */
# Verilator build and run for the rv_core testbench

VERILATOR  ?= verilator
TOP        ?= rv_core_tb
FILELIST   ?= build.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_TEXT  ?= >>> PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_TEXT)'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

/* build.f */
verilog/core_pkg.sv
verilog/pipe_reg.sv
verilog/fetch_unit.sv
verilog/decode_unit.sv
verilog/reg_file.sv
verilog/execute_unit.sv
verilog/retire_unit.sv
verilog/rv_core.sv
test/rv_core_props.sv
test/rv_core_tb.sv

/* test/rv_core_props.sv */
// Concurrent checks on the core retire port and retired counter, attached to rv_core by bind
module rv_core_props (
    input logic              clk,
    input logic              rst_i,
    input core_pkg::retire_t retire_o,
    input core_pkg::word_t   retired_count_o
);

    import core_pkg::*;

    int violations = 0;

    // Every pipeline register is cleared on a reset edge, so nothing can retire right after it
    no_retire_after_reset: assert property (@(posedge clk) rst_i |=> !retire_o.valid)
        else begin
            violations++;
            $error("retire_o.valid high in the cycle after a reset edge");
        end

    no_retire_after_release: assert property (@(posedge clk) $fell(rst_i) |=> !retire_o.valid)
        else begin
            violations++;
            $error("retire_o.valid high in the cycle after reset was released");
        end

    // Writes to x0 and non-writing instructions show zero data
    zero_data_for_x0: assert property (@(posedge clk) disable iff (rst_i)
        (retire_o.rd == '0) |-> (retire_o.data == '0))
        else begin
            violations++;
            $error("retire_o.data nonzero with rd equal to x0");
        end

    count_on_retire: assert property (@(posedge clk) disable iff (rst_i)
        retire_o.valid |=> (retired_count_o == $past(retired_count_o) + word_t'(1)))
        else begin
            violations++;
            $error("retired_count_o did not step after a retirement");
        end

    count_held_idle: assert property (@(posedge clk) disable iff (rst_i)
        !retire_o.valid |=> (retired_count_o == $past(retired_count_o)))
        else begin
            violations++;
            $error("retired_count_o changed without a retirement");
        end

endmodule

bind rv_core rv_core_props i_rv_core_props (
    .clk             (clk),
    .rst_i           (rst_i),
    .retire_o        (retire_o),
    .retired_count_o (retired_count_o)
);

/* test/rv_core_tb.sv */
// Testbench for rv_core that loads a program from the test data file and checks each retirement
module rv_core_tb;

    import core_pkg::*;

    localparam int IMEM_DEPTH = 256;
    localparam int DATA_WORDS = 512;

    logic     clk;
    logic     rst_i;
    imem_wr_t imem_wr_i;
    retire_t  retire_o;
    word_t    retired_count_o;

    word_t data_mem [DATA_WORDS];
    int    prog_words;
    int    num_records;
    int    rec_base;
    int    rec_idx;
    int    cycle_count;
    int    cycle_limit;
    int    pass_count;
    int    fail_count;
    int    test_errors;
    int    current_test;

    rv_core #(
        .IMEM_DEPTH (IMEM_DEPTH),
        .RESET_PC   (32'h0)
    ) i_rv_core (
        .clk             (clk),
        .rst_i           (rst_i),
        .imem_wr_i       (imem_wr_i),
        .retire_o        (retire_o),
        .retired_count_o (retired_count_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic string test_name(input int id);
        string name;
        case (id)
            1:       name = "arithmetic and immediates";
            2:       name = "forwarding";
            3:       name = "branches";
            4:       name = "JAL";
            5:       name = "x0 handling";
            default: name = "unknown";
        endcase
        return name;
    endfunction

    // Writes one program word per cycle through the load port while reset is high
    task automatic load_program();
        for (int i = 0; i < prog_words; i++) begin
            @(posedge clk);
            #1;
            imem_wr_i.we   = 1'b1;
            imem_wr_i.addr = 10'(i);
            imem_wr_i.data = data_mem[i + 1];
        end
        @(posedge clk);
        #1;
        imem_wr_i = '0;
    endtask

    task automatic report_test();
        if (current_test != 0) begin
            if (test_errors == 0) begin
                $display("[%0t] test %0d (%s) passed", $time, current_test,
                         test_name(current_test));
            end else begin
                $display("FAIL at %0t: test %0d (%s) had %0d wrong records", $time,
                         current_test, test_name(current_test), test_errors);
            end
        end
        test_errors = 0;
    endtask

    // Each record holds the test number, pc, rd and data as four words
    task automatic check_record(input int idx);
        int        base;
        int        test_id;
        word_t     exp_pc;
        reg_addr_t exp_rd;
        word_t     exp_data;
        base     = rec_base + 4 * idx;
        test_id  = int'(data_mem[base]);
        exp_pc   = data_mem[base + 1];
        exp_rd   = reg_addr_t'(data_mem[base + 2]);
        exp_data = data_mem[base + 3];
        if (test_id != current_test) begin
            report_test();
            current_test = test_id;
        end
        if (retire_o.pc !== exp_pc || retire_o.rd !== exp_rd || retire_o.data !== exp_data) begin
            $display("FAIL at %0t: record %0d is pc %h rd %0d data %h, expected %h %0d %h",
                     $time, idx, retire_o.pc, retire_o.rd, retire_o.data,
                     exp_pc, exp_rd, exp_data);
            fail_count++;
            test_errors++;
        end else begin
            pass_count++;
        end
    endtask

    // Ends the run if the retire stream stalls or goes missing
    initial begin
        cycle_count = 0;
        @(posedge clk);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        rst_i        = 1'b1;
        imem_wr_i    = '0;
        pass_count   = 0;
        fail_count   = 0;
        test_errors  = 0;
        current_test = 0;
        $readmemh("test/rv_core_testdata.txt", data_mem);
        prog_words  = int'(data_mem[0]);
        num_records = int'(data_mem[prog_words + 1]);
        rec_base    = prog_words + 2;
        cycle_limit = 8 * num_records + 40;

        // Reset stays high through the program load and then for eight more cycles
        load_program();
        repeat (8) @(posedge clk);
        #1;
        rst_i = 1'b0;

        rec_idx = 0;
        while (rec_idx < num_records) begin
            @(negedge clk);
            if (retire_o.valid) begin
                check_record(rec_idx);
                rec_idx++;
            end
        end
        report_test();

        // The counter steps on the edge after the last retirement
        @(negedge clk);
        if (retired_count_o !== word_t'(num_records)) begin
            $display("FAIL at %0t: retired count is %0d, expected %0d", $time,
                     retired_count_o, num_records);
            fail_count++;
        end else begin
            $display("[%0t] test 6 (retired counter) passed", $time);
            pass_count++;
        end

        if (i_rv_core.i_rv_core_props.violations != 0) begin
            $display("The bound assertions on the core failed %0d times",
                     i_rv_core.i_rv_core_props.violations);
            fail_count++;
        end

        $display("Checks passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* test/rv_core_testdata.txt */
// Program word count, program words, record count, then records with columns: test pc rd data
// Tests: 1 ALU and immediates, 2 forwarding, 3 branches, 4 JAL, 5 x0 handling
00000036
00500093 FFD00113 002081B3 40208233 004092B3 00112333 // pc 00
001133B3 0020C433 006154B3 40615533 0040E5B3 00B47633 // pc 18
00309693 40115713 FFF12793 0F017813 123458B7 00001917 // pc 30
6788E993 00100A13 014A0AB3 014A8B33 015A0BB3 416B8C33 // pc 48
00AA0A13 064A0A13 014A0CB3 00108663 00100D13 00200D13 // pc 60
00109463 00114663 00300D13 00400D13 00116463 0020D663 // pc 78
00500D13 00600D13 00117663 00700D13 00800D13 00900D93 // pc 90
000D9463 00900D13 00A00D13 00C00E6F 00B00D13 00C00D13 // pc A8
000E0E93 00500013 00100F33 ABCDE037 00000F93 0000006F // pc C0
0000002B
1 00000000 01 00000005    1 00000004 02 FFFFFFFD
1 00000008 03 00000002    1 0000000C 04 00000008
1 00000010 05 00000500    1 00000014 06 00000001
1 00000018 07 00000000    1 0000001C 08 FFFFFFF8
1 00000020 09 7FFFFFFE    1 00000024 0A FFFFFFFE
1 00000028 0B 0000000D    1 0000002C 0C 00000008
1 00000030 0D 00000028    1 00000034 0E FFFFFFFE
1 00000038 0F 00000001    1 0000003C 10 000000F0
1 00000040 11 12345000    1 00000044 12 00001044
1 00000048 13 12345678
2 0000004C 14 00000001    2 00000050 15 00000002
2 00000054 16 00000003    2 00000058 17 00000003
2 0000005C 18 00000000    2 00000060 14 0000000B
2 00000064 14 0000006F    2 00000068 19 000000DE
3 0000006C 00 00000000    3 00000078 00 00000000
3 0000007C 00 00000000    3 00000088 00 00000000
3 0000008C 00 00000000    3 00000098 00 00000000
3 000000A4 1B 00000009    3 000000A8 00 00000000
3 000000B0 1A 0000000A
4 000000B4 1C 000000B8    4 000000C0 1D 000000B8
5 000000C4 00 00000000    5 000000C8 1E 00000005
5 000000CC 00 00000000    5 000000D0 1F 00000000
5 000000D4 00 00000000

/* verilog/core_pkg.sv */
// Shared widths, RV32I opcode constants, ALU operations and pipeline payload structs for the core
package core_pkg;

    localparam int XLEN     = 32;
    localparam int NUM_REGS = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND,
        PASS_B
    } alu_op_e;

    // Major opcodes supported by this core
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // Program load port, addr is a word index
    typedef struct packed {
        logic       we;
        logic [9:0] addr;
        word_t      data;
    } imem_wr_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        alu_op_e    alu_op;
        logic       op1_is_pc;
        logic       op2_is_imm;
        logic       is_branch;
        logic       is_jal;
        logic       rf_en;
        logic [2:0] funct3;
    } ctrl_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        ctrl_t     ctrl;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        word_t     rs1_data;
        word_t     rs2_data;
        word_t     imm;
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        logic      rf_en;
        reg_addr_t rd;
        word_t     result;
        word_t     pc;
    } wb_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

    typedef struct packed {
        logic      rf_en;
        reg_addr_t rd;
        word_t     data;
    } fwd_src_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        reg_addr_t rd;
        word_t     data;
    } retire_t;

endpackage

/* verilog/decode_unit.sv */
// Decode stage that splits the instruction, builds immediates and control, and fills ID/EX
module decode_unit (
    input  logic               clk,
    input  logic               rst_i,
    input  core_pkg::if_id_t   if_id_i,
    input  logic               flush_i,
    output core_pkg::reg_addr_t rs1_o,
    output core_pkg::reg_addr_t rs2_o,
    input  core_pkg::word_t    rs1_data_i,
    input  core_pkg::word_t    rs2_data_i,
    output core_pkg::id_ex_t   id_ex_o
);

    import core_pkg::*;

    word_t      instr;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t  rd;
    word_t      imm_i;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;
    ctrl_t      ctrl;
    word_t      imm;
    logic       supported;
    id_ex_t     id_ex_d;

    // Shared ALU mapping for OP and OP-IMM; only OP can select SUB
    function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic f7_bit,
                                           input logic is_reg);
        alu_op_e op;
        case (f3)
            3'b000:  op = (is_reg && f7_bit) ? SUB : ADD;
            3'b001:  op = SLL;
            3'b010:  op = SLT;
            3'b011:  op = SLTU;
            3'b100:  op = XOR;
            3'b101:  op = f7_bit ? SRA : SRL;
            3'b110:  op = OR;
            default: op = AND;
        endcase
        return op;
    endfunction

    assign instr  = if_id_i.instr;
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rd     = instr[11:7];
    assign rs1_o  = instr[19:15];
    assign rs2_o  = instr[24:20];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = ADD;
        ctrl.funct3 = funct3;
        imm         = '0;
        supported   = 1'b1;
        case (opcode)
            OPC_OP: begin
                ctrl.alu_op = alu_decode(funct3, funct7[5], 1'b1);
                ctrl.rf_en  = 1'b1;
            end
            OPC_OP_IMM: begin
                ctrl.alu_op     = alu_decode(funct3, funct7[5], 1'b0);
                ctrl.op2_is_imm = 1'b1;
                ctrl.rf_en      = 1'b1;
                imm             = imm_i;
            end
            OPC_LUI: begin
                ctrl.alu_op     = PASS_B;
                ctrl.op2_is_imm = 1'b1;
                ctrl.rf_en      = 1'b1;
                imm             = imm_u;
            end
            OPC_AUIPC: begin
                ctrl.op1_is_pc  = 1'b1;
                ctrl.op2_is_imm = 1'b1;
                ctrl.rf_en      = 1'b1;
                imm             = imm_u;
            end
            OPC_JAL: begin
                ctrl.is_jal = 1'b1;
                ctrl.rf_en  = 1'b1;
                imm         = imm_j;
            end
            OPC_BRANCH: begin
                ctrl.is_branch = 1'b1;
                imm            = imm_b;
            end
            default: begin
                // Anything else drops out as a bubble
                supported = 1'b0;
            end
        endcase
    end

    // Non-writing instructions carry rd 0 so they retire with rd 0 and never forward
    assign id_ex_d.valid    = if_id_i.valid && supported;
    assign id_ex_d.pc       = if_id_i.pc;
    assign id_ex_d.ctrl     = ctrl;
    assign id_ex_d.rs1      = rs1_o;
    assign id_ex_d.rs2      = rs2_o;
    assign id_ex_d.rd       = ctrl.rf_en ? rd : '0;
    assign id_ex_d.rs1_data = rs1_data_i;
    assign id_ex_d.rs2_data = rs2_data_i;
    assign id_ex_d.imm      = imm;

    pipe_reg #(
        .PAYLOAD_T (id_ex_t)
    ) i_id_ex_reg (
        .clk     (clk),
        .rst_i   (rst_i),
        .flush_i (flush_i),
        .d_i     (id_ex_d),
        .q_o     (id_ex_o)
    );

endmodule

/* verilog/execute_unit.sv */
// Execute stage with operand forwarding, ALU, branch resolution and the fetch redirect
module execute_unit (
    input  core_pkg::id_ex_t    id_ex_i,
    input  core_pkg::fwd_src_t  mem_fwd_i,
    input  core_pkg::fwd_src_t  wb_fwd_i,
    output core_pkg::wb_t       ex_res_o,
    output core_pkg::redirect_t redirect_o
);

    import core_pkg::*;

    word_t rs1_val;
    word_t rs2_val;
    word_t op1;
    word_t op2;
    word_t alu_res;
    logic  br_cond;

    // The younger result in EX/MEM wins over MEM/WB
    function automatic word_t fwd_operand(input reg_addr_t rs, input word_t rf_data,
                                          input fwd_src_t mem_src, input fwd_src_t wb_src);
        word_t val;
        if (mem_src.rf_en && mem_src.rd != '0 && mem_src.rd == rs) begin
            val = mem_src.data;
        end else if (wb_src.rf_en && wb_src.rd != '0 && wb_src.rd == rs) begin
            val = wb_src.data;
        end else begin
            val = rf_data;
        end
        return val;
    endfunction

    assign rs1_val = fwd_operand(id_ex_i.rs1, id_ex_i.rs1_data, mem_fwd_i, wb_fwd_i);
    assign rs2_val = fwd_operand(id_ex_i.rs2, id_ex_i.rs2_data, mem_fwd_i, wb_fwd_i);

    assign op1 = id_ex_i.ctrl.op1_is_pc ? id_ex_i.pc : rs1_val;
    assign op2 = id_ex_i.ctrl.op2_is_imm ? id_ex_i.imm : rs2_val;

    always_comb begin
        case (id_ex_i.ctrl.alu_op)
            ADD:     alu_res = op1 + op2;
            SUB:     alu_res = op1 - op2;
            SLL:     alu_res = op1 << op2[4:0];
            SLT:     alu_res = {{(XLEN-1){1'b0}}, $signed(op1) < $signed(op2)};
            SLTU:    alu_res = {{(XLEN-1){1'b0}}, op1 < op2};
            XOR:     alu_res = op1 ^ op2;
            SRL:     alu_res = op1 >> op2[4:0];
            SRA:     alu_res = word_t'($signed(op1) >>> op2[4:0]);
            OR:      alu_res = op1 | op2;
            AND:     alu_res = op1 & op2;
            PASS_B:  alu_res = op2;
            default: alu_res = '0;
        endcase
    end

    // Branches always compare the two register operands
    always_comb begin
        case (id_ex_i.ctrl.funct3)
            F3_BEQ:  br_cond = (rs1_val == rs2_val);
            F3_BNE:  br_cond = (rs1_val != rs2_val);
            F3_BLT:  br_cond = ($signed(rs1_val) < $signed(rs2_val));
            F3_BGE:  br_cond = ($signed(rs1_val) >= $signed(rs2_val));
            F3_BLTU: br_cond = (rs1_val < rs2_val);
            F3_BGEU: br_cond = (rs1_val >= rs2_val);
            default: br_cond = 1'b0;
        endcase
    end

    assign redirect_o.taken  = id_ex_i.valid &&
                               (id_ex_i.ctrl.is_jal || (id_ex_i.ctrl.is_branch && br_cond));
    assign redirect_o.target = id_ex_i.pc + id_ex_i.imm;

    assign ex_res_o.valid  = id_ex_i.valid;
    assign ex_res_o.rf_en  = id_ex_i.valid && id_ex_i.ctrl.rf_en;
    assign ex_res_o.rd     = id_ex_i.rd;
    assign ex_res_o.result = id_ex_i.ctrl.is_jal ? id_ex_i.pc + word_t'(4) : alu_res;
    assign ex_res_o.pc     = id_ex_i.pc;

endmodule

/* verilog/fetch_unit.sv */
// Fetch stage with PC, loadable instruction memory and the IF/ID register feeding decode
module fetch_unit #(
    parameter int              IMEM_DEPTH = 256,
    parameter core_pkg::word_t RESET_PC   = '0
) (
    input  logic                 clk,
    input  logic                 rst_i,
    input  core_pkg::imem_wr_t   imem_wr_i,
    input  core_pkg::redirect_t  redirect_i,
    output core_pkg::if_id_t     if_id_o
);

    import core_pkg::*;

    localparam int AW = $clog2(IMEM_DEPTH);

    word_t  imem [IMEM_DEPTH];
    word_t  pc_q;
    word_t  pc_next;
    if_id_t if_id_d;

    // Program words are only accepted while the core is held in reset
    always_ff @(posedge clk) begin
        if (rst_i && imem_wr_i.we) begin
            imem[imem_wr_i.addr[AW-1:0]] <= imem_wr_i.data;
        end
    end

    assign pc_next = redirect_i.taken ? redirect_i.target : pc_q + word_t'(4);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

    // Memory is read asynchronously so the word lands in IF/ID at the next edge
    assign if_id_d.valid = 1'b1;
    assign if_id_d.pc    = pc_q;
    assign if_id_d.instr = imem[pc_q[AW+1:2]];

    pipe_reg #(
        .PAYLOAD_T (if_id_t)
    ) i_if_id_reg (
        .clk     (clk),
        .rst_i   (rst_i),
        .flush_i (redirect_i.taken),
        .d_i     (if_id_d),
        .q_o     (if_id_o)
    );

endmodule

/* verilog/pipe_reg.sv */
// Generic pipeline stage register for any packed payload, cleared to a bubble on reset or flush
module pipe_reg #(
    parameter type PAYLOAD_T = logic [0:0]
) (
    input  logic     clk,
    input  logic     rst_i,
    input  logic     flush_i,
    input  PAYLOAD_T d_i,
    output PAYLOAD_T q_o
);

    // An all-zero payload has its valid bit low, so it travels as a bubble
    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            q_o <= '0;
        end else begin
            q_o <= d_i;
        end
    end

endmodule

/* verilog/reg_file.sv */
// Integer register file with two asynchronous read ports, one write port and write-through
module reg_file (
    input  logic                clk,
    input  logic                rst_i,
    input  core_pkg::reg_addr_t rs1_i,
    input  core_pkg::reg_addr_t rs2_i,
    output core_pkg::word_t     rs1_data_o,
    output core_pkg::word_t     rs2_data_o,
    input  logic                we_i,
    input  core_pkg::word_t     wd_i,
    input  core_pkg::reg_addr_t wa_i
);

    import core_pkg::*;

    word_t regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && wa_i != '0) begin
            regs[wa_i] <= wd_i;
        end
    end

    // x0 reads zero; a write in the same cycle is passed straight through
    assign rs1_data_o = (rs1_i == '0) ? '0 :
                        (we_i && wa_i == rs1_i) ? wd_i : regs[rs1_i];
    assign rs2_data_o = (rs2_i == '0) ? '0 :
                        (we_i && wa_i == rs2_i) ? wd_i : regs[rs2_i];

endmodule

/* verilog/retire_unit.sv */
// Memory-slot and writeback stages feeding forwarding, the register write, retire port and counter
module retire_unit (
    input  logic                clk,
    input  logic                rst_i,
    input  core_pkg::wb_t       ex_res_i,
    output core_pkg::fwd_src_t  mem_fwd_o,
    output core_pkg::fwd_src_t  wb_fwd_o,
    output logic                rf_we_o,
    output core_pkg::reg_addr_t rf_wa_o,
    output core_pkg::word_t     rf_wd_o,
    output core_pkg::retire_t   retire_o,
    output core_pkg::word_t     retired_count_o
);

    import core_pkg::*;

    wb_t ex_mem;
    wb_t mem_wb;

    // Nothing past execute is ever flushed
    pipe_reg #(
        .PAYLOAD_T (wb_t)
    ) i_ex_mem_reg (
        .clk     (clk),
        .rst_i   (rst_i),
        .flush_i (1'b0),
        .d_i     (ex_res_i),
        .q_o     (ex_mem)
    );

    pipe_reg #(
        .PAYLOAD_T (wb_t)
    ) i_mem_wb_reg (
        .clk     (clk),
        .rst_i   (rst_i),
        .flush_i (1'b0),
        .d_i     (ex_mem),
        .q_o     (mem_wb)
    );

    assign mem_fwd_o.rf_en = ex_mem.valid && ex_mem.rf_en;
    assign mem_fwd_o.rd    = ex_mem.rd;
    assign mem_fwd_o.data  = ex_mem.result;

    assign wb_fwd_o.rf_en = mem_wb.valid && mem_wb.rf_en;
    assign wb_fwd_o.rd    = mem_wb.rd;
    assign wb_fwd_o.data  = mem_wb.result;

    assign rf_we_o = mem_wb.valid && mem_wb.rf_en && mem_wb.rd != '0;
    assign rf_wa_o = mem_wb.rd;
    assign rf_wd_o = mem_wb.result;

    // Retire data shows only what actually reaches the register file
    assign retire_o.valid = mem_wb.valid;
    assign retire_o.pc    = mem_wb.pc;
    assign retire_o.rd    = mem_wb.rd;
    assign retire_o.data  = rf_we_o ? mem_wb.result : '0;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            retired_count_o <= '0;
        end else if (mem_wb.valid) begin
            retired_count_o <= retired_count_o + word_t'(1);
        end
    end

endmodule

/* verilog/rv_core.sv */
// Top level of the five-stage RV32I core, connecting fetch, decode, register file, execute and retire
module rv_core #(
    parameter int              IMEM_DEPTH = 256,
    parameter core_pkg::word_t RESET_PC   = '0
) (
    input  logic               clk,
    input  logic               rst_i,
    input  core_pkg::imem_wr_t imem_wr_i,
    output core_pkg::retire_t  retire_o,
    output core_pkg::word_t    retired_count_o
);

    import core_pkg::*;

    if_id_t    if_id;
    id_ex_t    id_ex;
    wb_t       ex_res;
    redirect_t redirect;
    fwd_src_t  mem_fwd;
    fwd_src_t  wb_fwd;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;
    logic      rf_we;
    reg_addr_t rf_wa;
    word_t     rf_wd;

    fetch_unit #(
        .IMEM_DEPTH (IMEM_DEPTH),
        .RESET_PC   (RESET_PC)
    ) i_fetch_unit (
        .clk        (clk),
        .rst_i      (rst_i),
        .imem_wr_i  (imem_wr_i),
        .redirect_i (redirect),
        .if_id_o    (if_id)
    );

    // A taken redirect also squashes the instruction sitting in decode
    decode_unit i_decode_unit (
        .clk        (clk),
        .rst_i      (rst_i),
        .if_id_i    (if_id),
        .flush_i    (redirect.taken),
        .rs1_o      (rs1_addr),
        .rs2_o      (rs2_addr),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .id_ex_o    (id_ex)
    );

    reg_file i_reg_file (
        .clk        (clk),
        .rst_i      (rst_i),
        .rs1_i      (rs1_addr),
        .rs2_i      (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .we_i       (rf_we),
        .wd_i       (rf_wd),
        .wa_i       (rf_wa)
    );

    execute_unit i_execute_unit (
        .id_ex_i    (id_ex),
        .mem_fwd_i  (mem_fwd),
        .wb_fwd_i   (wb_fwd),
        .ex_res_o   (ex_res),
        .redirect_o (redirect)
    );

    retire_unit i_retire_unit (
        .clk             (clk),
        .rst_i           (rst_i),
        .ex_res_i        (ex_res),
        .mem_fwd_o       (mem_fwd),
        .wb_fwd_o        (wb_fwd),
        .rf_we_o         (rf_we),
        .rf_wa_o         (rf_wa),
        .rf_wd_o         (rf_wd),
        .retire_o        (retire_o),
        .retired_count_o (retired_count_o)
    );

endmodule
